//--- intr_pkg.sv
// interrupt controller shared definitions.
// level count defaults, APB request/response structs,
// register offset map and APB phase encoding.

`default_nettype none

package intr_pkg;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // sizing defaults.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  localparam int N_LEVELS_DEF = 16;  // sixteen request lines, level 15 highest.
  localparam int LVL_W_DEF    = 4;   // bits needed to number sixteen levels.
  localparam int APB_DW       = 16;  // width of the APB data buses.

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // APB port bundles.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // master to slave, held stable from setup through access.
  typedef struct packed {
    logic              psel;     // slave selected.
    logic              penable;  // second cycle of a transfer.
    logic              pwrite;   // high for a write, low for a read.
    logic [3:0]        paddr;    // byte offset into the register block.
    logic [APB_DW-1:0] pwdata;   // write data.
  } apb_req_t;

  // slave to master.
  typedef struct packed {
    logic [APB_DW-1:0] prdata;   // read data, valid in the access phase.
    logic              pready;   // no wait states, high in every access.
    logic              pslverr;  // unmapped offset.
  } apb_rsp_t;

  // register offsets. The vector register carries valid in bit 15
  // and the winning level in the low bits.
  typedef enum logic [3:0] {
    REG_PEND   = 4'h0,  // read only, pending bits.
    REG_MASK   = 4'h4,  // read/write, enable mask.
    REG_CLEAR  = 4'h8,  // write only, write-one-to-clear.
    REG_VECTOR = 4'hC   // read only, read acknowledges the level.
  } reg_addr_e;

  // phase seen on the bus in the previous cycle.
  typedef enum logic [1:0] {
    ST_IDLE   = 2'd0,
    ST_SETUP  = 2'd1,
    ST_ACCESS = 2'd2
  } apb_state_e;

endpackage

`default_nettype wire

//--- irq_req_reg.sv
// interrupt request latch bank.
// one pending bit per level, set by a low sample of its
// irq_n line and cleared by the matching clr bit.

`timescale 1ns/100ps
`default_nettype none

module irq_req_reg
  import intr_pkg::*;
#(
  parameter int N_LEVELS = N_LEVELS_DEF
) (
  input  logic                mclk,   // master clock, rising edge only.
  input  logic                rst_n,  // asynchronous reset, active low.
  input  logic [N_LEVELS-1:0] irq_n,  // request lines, active low.
  input  logic [N_LEVELS-1:0] clr,    // per-bit clear, one cycle wide.
  output logic [N_LEVELS-1:0] pend    // latched requests.
);

  logic [N_LEVELS-1:0] pend_q;  // the latch bank itself.

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // per-level request latch.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // each bit is its own small flop so a level can be set and
  // cleared independently of the others.
  for (genvar i = 0; i < N_LEVELS; i++) begin : g_rqbit
    logic set_req;  // low sample on this line.
    logic hold;     // keep the bit unless software clears it.

    assign set_req = ~irq_n[i];
    assign hold    = pend_q[i] & ~clr[i];

    always_ff @(posedge mclk or negedge rst_n) begin
      if (!rst_n) begin
        pend_q[i] <= 1'b0;  // nothing pending out of reset.
      end else begin
        // set wins over clear. A line still held low after an
        // acknowledge is therefore seen again on the next edge.
        pend_q[i] <= set_req | hold;
      end
    end
  end

  // the pending vector is read by the priority encoder and
  // by the APB side in the same cycle it changes.
  assign pend = pend_q;

endmodule

`default_nettype wire

//--- irq_priority_enc.sv
// interrupt priority encoder.
// masks the pending bits, picks the highest enabled level
// and drives the interrupt output.

`timescale 1ns/100ps
`default_nettype none

module irq_priority_enc
  import intr_pkg::*;
#(
  parameter int N_LEVELS = N_LEVELS_DEF,
  parameter int LVL_W    = LVL_W_DEF
) (
  input  logic [N_LEVELS-1:0] pend,       // latched requests.
  input  logic [N_LEVELS-1:0] mask,       // enable per level, 1 = enabled.
  output logic [LVL_W-1:0]    top_level,  // highest enabled pending level.
  output logic                top_valid,  // some enabled level is pending.
  output logic                irq         // interrupt to the CPU.
);

  logic [N_LEVELS-1:0] active;  // pending and enabled.

  assign active = pend & mask;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // highest level search.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // scan from the top level down and stop at the first active
  // bit. With nothing active the level reads zero.
  always_comb begin
    logic found;

    found     = 1'b0;
    top_level = '0;
    for (int i = N_LEVELS - 1; i >= 0; i--) begin
      if (active[i] && !found) begin
        top_level = LVL_W'(i);  // first hit is the winner.
        found     = 1'b1;
      end
    end
    top_valid = found;
  end

  // irq is just the OR of the enabled requests, it is not
  // registered so it follows pend and mask in the same cycle.
  assign irq = |active;

endmodule

`default_nettype wire

//--- intr_apb_ctrl.sv
// APB slave for the interrupt controller.
// phase tracking FSM, enable mask register, read mux,
// write-one-to-clear and acknowledge on vector read.

`timescale 1ns/100ps
`default_nettype none

module intr_apb_ctrl
  import intr_pkg::*;
#(
  parameter int N_LEVELS = N_LEVELS_DEF,
  parameter int LVL_W    = LVL_W_DEF
) (
  input  logic                mclk,       // master clock.
  input  logic                rst_n,      // asynchronous reset, active low.
  input  apb_req_t            apb_req,    // bus request from the CPU.
  output apb_rsp_t            apb_rsp,    // bus response to the CPU.
  input  logic [N_LEVELS-1:0] pend,       // pending bits from the latch bank.
  input  logic [LVL_W-1:0]    top_level,  // winning level.
  input  logic                top_valid,  // winner exists.
  output logic [N_LEVELS-1:0] mask,       // enable mask to the encoder.
  output logic [N_LEVELS-1:0] clr         // per-bit clear to the latch bank.
);

  apb_state_e          state_q;   // bus phase seen in the previous cycle.
  apb_state_e          state_d;
  logic [N_LEVELS-1:0] mask_q;    // enable mask register.
  logic                acc;       // access phase of a proper transfer.
  logic                mapped;    // paddr hits a register.
  logic [APB_DW-1:0]   rd_data;   // read mux output.
  logic [N_LEVELS-1:0] wr_clr;    // clear bits from a CLEAR write.
  logic [N_LEVELS-1:0] ack_clr;   // one-hot clear from a vector read.

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // bus phase tracking.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  always_comb begin
    if (apb_req.psel && !apb_req.penable) state_d = ST_SETUP;
    else if (apb_req.psel)                state_d = ST_ACCESS;
    else                                  state_d = ST_IDLE;
  end

  always_ff @(posedge mclk or negedge rst_n) begin
    if (!rst_n) state_q <= ST_IDLE;
    else        state_q <= state_d;
  end

  // a transfer acts once, in the access cycle right after setup.
  assign acc = apb_req.psel & apb_req.penable & (state_q == ST_SETUP);

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // address decode and read mux.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  always_comb begin
    mapped  = 1'b1;
    rd_data = '0;  // unused bits read as zero.
    case (reg_addr_e'(apb_req.paddr))
      REG_PEND:   rd_data[N_LEVELS-1:0] = pend;
      REG_MASK:   rd_data[N_LEVELS-1:0] = mask_q;
      REG_CLEAR:  rd_data = '0;  // write only.
      REG_VECTOR: begin
        rd_data[APB_DW-1]  = top_valid;  // valid flag in bit 15.
        rd_data[LVL_W-1:0] = top_level;
      end
      default:    mapped = 1'b0;
    endcase
  end

  // no wait states. pslverr only for an unmapped offset.
  assign apb_rsp.prdata  = rd_data;
  assign apb_rsp.pready  = apb_req.psel & apb_req.penable;
  assign apb_rsp.pslverr = apb_req.psel & apb_req.penable & ~mapped;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // mask register and clear strobes.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  always_ff @(posedge mclk or negedge rst_n) begin
    if (!rst_n) begin
      mask_q <= '0;  // all levels disabled.
    end else if (acc && apb_req.pwrite && reg_addr_e'(apb_req.paddr) == REG_MASK) begin
      mask_q <= apb_req.pwdata[N_LEVELS-1:0];
    end
  end

  always_comb begin
    wr_clr  = '0;
    ack_clr = '0;
    if (acc && apb_req.pwrite && reg_addr_e'(apb_req.paddr) == REG_CLEAR)
      wr_clr = apb_req.pwdata[N_LEVELS-1:0];  // write-one-to-clear.
    // reading the vector acknowledges the level it returns.
    if (acc && !apb_req.pwrite && reg_addr_e'(apb_req.paddr) == REG_VECTOR && top_valid)
      ack_clr[top_level] = 1'b1;
  end

  assign clr  = wr_clr | ack_clr;  // taken by the latches at the end of access.
  assign mask = mask_q;

endmodule

`default_nettype wire

//--- intr_cntlr_top.sv
// interrupt controller top level.
// request latch bank, priority encoder and APB slave,
// with the APB port, request lines and irq brought out.

`timescale 1ns/100ps
`default_nettype none

module intr_cntlr_top
  import intr_pkg::*;
#(
  parameter int N_LEVELS = N_LEVELS_DEF
) (
  input  logic                mclk,     // master clock.
  input  logic                rst_n,    // asynchronous reset, active low.
  input  apb_req_t            apb_req,  // APB request from the CPU.
  output apb_rsp_t            apb_rsp,  // APB response.
  input  logic [N_LEVELS-1:0] irq_n,    // request lines, active low.
  output logic                irq       // interrupt to the CPU.
);

  // level number width follows the level count.
  localparam int LVL_W = (N_LEVELS > 1) ? $clog2(N_LEVELS) : 1;

  logic [N_LEVELS-1:0] pend;       // latched requests.
  logic [N_LEVELS-1:0] mask;       // enable mask.
  logic [N_LEVELS-1:0] clr;        // clear strobes to the latches.
  logic [LVL_W-1:0]    top_level;  // winning level.
  logic                top_valid;  // winner exists.

  irq_req_reg #(.N_LEVELS(N_LEVELS)) u_req_reg (
    .mclk (mclk),
    .rst_n(rst_n),
    .irq_n(irq_n),
    .clr  (clr),
    .pend (pend)
  );

  irq_priority_enc #(.N_LEVELS(N_LEVELS), .LVL_W(LVL_W)) u_prio_enc (
    .pend     (pend),
    .mask     (mask),
    .top_level(top_level),
    .top_valid(top_valid),
    .irq      (irq)
  );

  intr_apb_ctrl #(.N_LEVELS(N_LEVELS), .LVL_W(LVL_W)) u_apb_ctrl (
    .mclk     (mclk),
    .rst_n    (rst_n),
    .apb_req  (apb_req),
    .apb_rsp  (apb_rsp),
    .pend     (pend),
    .top_level(top_level),
    .top_valid(top_valid),
    .mask     (mask),
    .clr      (clr)
  );

endmodule

`default_nettype wire

//--- tb_clk_gen.sv
// testbench clock and reset source.
// free running mclk and an active low reset held for a few cycles.

`timescale 1ns/100ps
`default_nettype none

module tb_clk_gen #(
  parameter int PERIOD     = 10,  // clock period in ns.
  parameter int RST_CYCLES = 3    // rising edges seen with reset held.
) (
  output logic mclk,  // master clock.
  output logic rst_n  // asynchronous reset, active low.
);

  initial mclk = 1'b0;
  always #(PERIOD / 2) mclk = ~mclk;

  // reset is released on a falling edge, away from the flops' edge.
  initial begin
    rst_n = 1'b0;
    repeat (RST_CYCLES) @(posedge mclk);
    @(negedge mclk);
    rst_n = 1'b1;
  end

endmodule

`default_nettype wire

//--- intr_cntlr_tb.sv
// testbench for the interrupt controller.
// stimulus table with hand worked expectations, random entries
// predicted by a reference model, APB driver, checks and watchdog.

`timescale 1ns/100ps
`default_nettype none

module intr_cntlr_tb
  import intr_pkg::*;
();

  localparam int CLK_PERIOD  = 10;
  localparam int SAMPLE_DLY  = 4;   // 1 ns before the rising edge.
  localparam int TABLE_LEN   = 25;  // hand written entries.
  localparam int N_RAND      = 40;  // model predicted entries.
  localparam int WATCHDOG_NS = ((TABLE_LEN + N_RAND) * 20 + 200) * CLK_PERIOD;

  typedef enum logic {OP_RD, OP_WR} op_e;

  // one stimulus step is an irq_n pattern followed by one APB transfer.
  typedef struct packed {
    logic [15:0] pat;         // irq_n value driven in the first cycle.
    logic        hold;        // keep the pattern through the transfer.
    op_e         op;
    logic [3:0]  addr;
    logic [15:0] wdata;
    logic [15:0] exp_rd;      // read data, checked on mapped reads.
    logic        exp_err;     // pslverr expected.
    logic        exp_irq;     // irq in the cycle after the access.
    logic        from_model;  // expectations come from the model.
  } entry_t;

  logic                    mclk;
  logic                    rst_n;
  apb_req_t                apb_req;
  apb_rsp_t                apb_rsp;
  logic [N_LEVELS_DEF-1:0] irq_n;
  logic                    irq;

  entry_t      tbl[$];     // the stimulus table.
  logic [15:0] pend_m;     // model of the pending bits.
  logic [15:0] mask_m;     // model of the enable mask.
  logic [31:0] rng;        // xorshift state.
  int          n_checks;
  int          n_errors;

  tb_clk_gen #(.PERIOD(CLK_PERIOD), .RST_CYCLES(3)) u_clk (.mclk(mclk), .rst_n(rst_n));

  intr_cntlr_top #(.N_LEVELS(N_LEVELS_DEF)) DUT (
    .mclk   (mclk),
    .rst_n  (rst_n),
    .apb_req(apb_req),
    .apb_rsp(apb_rsp),
    .irq_n  (irq_n),
    .irq    (irq)
  );

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // stimulus construction.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    s = s ^ (s << 13);
    s = s ^ (s >> 17);
    s = s ^ (s << 5);
    return s;
  endfunction

  function automatic void add_entry(logic [15:0] pat, logic hold, op_e op, logic [3:0] addr,
                                    logic [15:0] wdata, logic [15:0] exp_rd, logic exp_err,
                                    logic exp_irq);
    entry_t e;
    e = '{pat, hold, op, addr, wdata, exp_rd, exp_err, exp_irq, 1'b0};
    tbl.push_back(e);
  endfunction

  task automatic build_table();
    add_entry(16'hFFFF, 0, OP_RD, REG_PEND,   16'h0000, 16'h0000, 0, 0);  // reset values.
    add_entry(16'hFFFF, 0, OP_RD, REG_MASK,   16'h0000, 16'h0000, 0, 0);
    add_entry(16'hFFFF, 0, OP_RD, REG_VECTOR, 16'h0000, 16'h0000, 0, 0);
    add_entry(16'hFFF7, 0, OP_RD, REG_PEND,   16'h0000, 16'h0008, 0, 0);  // pulse level 3.
    add_entry(16'hFFFF, 0, OP_RD, REG_PEND,   16'h0000, 16'h0008, 0, 0);  // bit stays set.
    add_entry(16'hEFFF, 0, OP_RD, REG_PEND,   16'h0000, 16'h1008, 0, 0);  // pulse level 12.
    add_entry(16'hFFFF, 0, OP_WR, REG_MASK,   16'h0010, 16'h0000, 0, 0);  // none enabled pending.
    add_entry(16'hFFFF, 0, OP_RD, REG_MASK,   16'h0000, 16'h0010, 0, 0);
    add_entry(16'hFFFF, 0, OP_WR, REG_MASK,   16'h1018, 16'h0000, 0, 1);  // enables 12 and 3.
    add_entry(16'hFFFF, 0, OP_RD, REG_MASK,   16'h0000, 16'h1018, 0, 1);
    add_entry(16'hFF5F, 0, OP_RD, REG_PEND,   16'h0000, 16'h10A8, 0, 1);  // masked levels 7 and 5.
    add_entry(16'hFFFF, 0, OP_RD, REG_VECTOR, 16'h0000, 16'h800C, 0, 1);  // level 12 wins.
    add_entry(16'hFFFF, 0, OP_RD, REG_VECTOR, 16'h0000, 16'h8003, 0, 0);  // then level 3.
    add_entry(16'hFFFF, 0, OP_RD, REG_VECTOR, 16'h0000, 16'h0000, 0, 0);  // walked down to empty.
    add_entry(16'hFFFF, 0, OP_WR, REG_MASK,   16'hFFFF, 16'h0000, 0, 1);
    add_entry(16'hFFDF, 1, OP_WR, REG_CLEAR,  16'h00A0, 16'h0000, 0, 1);  // level 5 held low.
    add_entry(16'hFFFF, 0, OP_RD, REG_PEND,   16'h0000, 16'h0020, 0, 1);
    add_entry(16'hFFFC, 0, OP_WR, REG_CLEAR,  16'h0001, 16'h0000, 0, 1);  // clears level 0 only.
    add_entry(16'hFFFF, 0, OP_RD, REG_PEND,   16'h0000, 16'h0022, 0, 1);
    add_entry(16'hFFFF, 0, OP_RD, 4'h2,       16'h0000, 16'h0000, 1, 1);  // unmapped offsets.
    add_entry(16'hFFFF, 0, OP_WR, 4'h6,       16'h0022, 16'h0000, 1, 1);  // must not touch state.
    add_entry(16'hFFFF, 0, OP_RD, REG_MASK,   16'h0000, 16'hFFFF, 0, 1);
    add_entry(16'hFFFF, 0, OP_RD, REG_PEND,   16'h0000, 16'h0022, 0, 1);
    add_entry(16'hFFFF, 0, OP_WR, REG_CLEAR,  16'hFFFF, 16'h0000, 0, 0);
    add_entry(16'hFFFF, 0, OP_RD, REG_VECTOR, 16'h0000, 16'h0000, 0, 0);
  endtask

  // random entries use sparse request patterns and a mix of accesses.
  task automatic add_random();
    entry_t      e;
    logic [31:0] r1;
    logic [31:0] r2;
    for (int i = 0; i < N_RAND; i++) begin
      rng = xorshift32(rng);
      r1  = rng;
      rng = xorshift32(rng);
      r2  = rng;
      e            = '0;
      e.from_model = 1'b1;
      e.pat        = ~(r1[15:0] & r1[31:16]);  // about a quarter of the lines low.
      e.hold       = r2[7];
      e.wdata      = r2[31:16];
      e.op         = r2[2] ? OP_WR : OP_RD;
      case (r2[1:0])
        2'd0:    e.addr = r2[2] ? REG_CLEAR : REG_VECTOR;
        2'd1:    e.addr = r2[2] ? REG_MASK : REG_PEND;
        2'd2:    e.addr = r2[2] ? REG_CLEAR : REG_MASK;
        default: e.addr = {r2[5:4], 2'b10};  // never a register offset.
      endcase
      tbl.push_back(e);
    end
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // reference model.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // the last hit of an upward scan is the highest level.
  function automatic logic [15:0] top_vector(input logic [15:0] act);
    logic [15:0] v;
    v = '0;
    for (int i = 0; i < 16; i++) begin
      if (act[i]) v = 16'h8000 | 16'(i);
    end
    return v;
  endfunction

  // fills the expectations of one entry and advances pend and mask.
  task automatic predict(inout entry_t e);
    logic [15:0] pend_c;
    logic [15:0] vec;
    logic [15:0] clr;
    pend_c    = pend_m | ~e.pat;  // as seen in the access cycle.
    vec       = top_vector(pend_c & mask_m);
    clr       = '0;
    e.exp_rd  = '0;
    e.exp_err = (e.addr[1:0] != 2'b00);  // registers sit on word offsets only.
    if (!e.exp_err) begin
      case (e.addr)
        REG_PEND: e.exp_rd = pend_c;
        REG_MASK: e.exp_rd = mask_m;
        REG_VECTOR: begin
          e.exp_rd = vec;
          if (e.op == OP_RD && vec[15]) clr[vec[3:0]] = 1'b1;  // acknowledge.
        end
        default: if (e.op == OP_WR) clr = e.wdata;
      endcase
      if (e.op == OP_WR && e.addr == REG_MASK) mask_m = e.wdata;
    end
    // a line still held low sets its bit again because set beats clear.
    pend_m    = (pend_c & ~clr) | (e.hold ? ~e.pat : 16'h0000);
    e.exp_irq = |(pend_m & mask_m);
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // bus driver and checks.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  task automatic run_entry(input entry_t e, output logic [15:0] rd, output logic rdy,
                           output logic err, output logic irq_o);
    @(negedge mclk);
    irq_n   = e.pat;
    apb_req = '0;
    @(negedge mclk);
    if (!e.hold) irq_n = '1;
    apb_req.psel   = 1'b1;  // setup phase.
    apb_req.pwrite = (e.op == OP_WR);
    apb_req.paddr  = e.addr;
    apb_req.pwdata = e.wdata;
    @(negedge mclk);
    apb_req.penable = 1'b1;  // access phase with no wait states.
    #(SAMPLE_DLY);
    rd  = apb_rsp.prdata;
    rdy = apb_rsp.pready;
    err = apb_rsp.pslverr;
    @(negedge mclk);
    apb_req = '0;
    #(SAMPLE_DLY);
    irq_o = irq;  // reflects the register changes of the access.
  endtask

  task automatic report(input int idx, input string msg);
    n_errors++;
    $display("CHECK FAILED at %0d ns: entry %0d, %s", $time, idx, msg);
  endtask

  task automatic check_entry(input int idx, input entry_t e, input logic [15:0] rd,
                             input logic rdy, input logic err, input logic irq_o);
    n_checks += 3;
    assert (rdy === 1'b1) else report(idx, "pready low in the access phase");
    assert (err === e.exp_err)
      else report(idx, $sformatf("pslverr %b, expected %b", err, e.exp_err));
    assert (irq_o === e.exp_irq)
      else report(idx, $sformatf("irq %b, expected %b", irq_o, e.exp_irq));
    if (e.op == OP_RD && !e.exp_err) begin
      n_checks++;
      assert (rd === e.exp_rd)
        else report(idx, $sformatf("prdata %h at offset %h, expected %h", rd, e.addr, e.exp_rd));
    end
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // main sequence and watchdog.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  initial begin
    entry_t      e;
    entry_t      m;
    logic [15:0] rd;
    logic        rdy;
    logic        err;
    logic        irq_o;
    irq_n    = '1;  // no requests during reset.
    apb_req  = '0;
    pend_m   = '0;
    mask_m   = '0;
    n_checks = 0;
    n_errors = 0;
    rng      = 32'd23232;
    build_table();
    add_random();
    wait (rst_n === 1'b1);
    for (int i = 0; i < tbl.size(); i++) begin
      e = tbl[i];
      m = e;
      predict(m);  // the model runs through the table entries too.
      if (e.from_model) e = m;
      run_entry(e, rd, rdy, err, irq_o);
      check_entry(i, e, rd, rdy, err, irq_o);
    end
    repeat (2) @(negedge mclk);
    $display("%0d checks run, %0d errors", n_checks, n_errors);
    if (n_errors == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

  initial begin
    #(WATCHDOG_NS);
    $display("watchdog expired at %0d ns before the sequence finished", $time);
    $display("tests failed");
    $finish;
  end

endmodule

`default_nettype wire

//--- vlog.f
intr_pkg.sv
irq_req_reg.sv
irq_priority_enc.sv
intr_apb_ctrl.sv
intr_cntlr_top.sv
tb_clk_gen.sv
intr_cntlr_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Builds the interrupt controller testbench with Verilator, runs it
# and decides pass or fail from the simulation log.

set -u
cd "$(dirname "$0")" || exit 1

LOG=sim.log
BIN=intr_cntlr_sim

verilator --binary --timing --assert -f vlog.f --top-module intr_cntlr_tb -o "$BIN"
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/"$BIN" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -qx "all tests passed" "$LOG"; then
  exit 0
else
  echo "pass message not found in $LOG"
  exit 1
fi
